// ==== Makefile ====
# Verilator build and run for the UMI merge testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= umi_merge_tb
FILELIST  ?= umi_merge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/umi_arb_pkg.sv ====
/*
 * Arbitration constants for the 2:1 combiner.
 * Port 0 is the high-priority response/write input, port 1 the
 * low-priority read-request input. Grants are one-hot.
 */
package umi_arb_pkg;

   localparam int n_ports   = 2;  // Combiner inputs
   localparam int port_resp = 0;  // High priority, lowest index wins
   localparam int port_req  = 1;  // Low priority

   // One-hot grant, also used for valid and ready vectors
   typedef logic [n_ports-1:0] grant_t;

endpackage

// ==== hdl/umi_combiner.sv ====
/*
 * Response/request 2:1 combiner.
 * Responses and writes on resp_in win over read requests on req_in.
 * Fully combinational in the data path; sources must self-throttle and
 * the combiner must not sit inside a loop or traffic can deadlock.
 */
`timescale 1ns/1ps

module umi_combiner (
   input  logic              clk,
   input  logic              arst_n,
   // High priority input
   input  logic              resp_in_valid,
   input  umi_pkg::umi_msg_t resp_in_msg,
   output logic              resp_in_ready,
   // Low priority input
   input  logic              req_in_valid,
   input  umi_pkg::umi_msg_t req_in_msg,
   output logic              req_in_ready,
   // Merged output
   output logic              out_valid,
   output umi_pkg::umi_msg_t out_msg,
   input  logic              out_ready
);

   umi_arb_pkg::grant_t                          valid_vec;
   umi_arb_pkg::grant_t                          port_ready;  // Grant from mux
   umi_pkg::umi_msg_t [umi_arb_pkg::n_ports-1:0] msg_vec;

   // Named inputs onto mux lanes
   assign valid_vec[umi_arb_pkg::port_resp] = resp_in_valid;
   assign valid_vec[umi_arb_pkg::port_req]  = req_in_valid;
   assign msg_vec[umi_arb_pkg::port_resp]   = resp_in_msg;
   assign msg_vec[umi_arb_pkg::port_req]    = req_in_msg;

   umi_mux #(
      .msg_t (umi_pkg::umi_msg_t)
   ) u_mux (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (valid_vec),
      .in_msg    (msg_vec),
      .in_ready  (port_ready),
      .out_valid (out_valid),
      .out_msg   (out_msg),
      .out_ready (out_ready)
   );

   // Flow-through pushback
   assign resp_in_ready = out_ready & port_ready[umi_arb_pkg::port_resp];
   assign req_in_ready  = out_ready & port_ready[umi_arb_pkg::port_req];

endmodule

// ==== hdl/umi_merge_top.sv ====
/*
 * UMI merge top level.
 * 2:1 priority combiner feeding a registered output slice, so an
 * accepted message reaches out_valid one cycle later and the
 * downstream consumer sees only flop outputs.
 */
`timescale 1ns/1ps

module umi_merge_top (
   input  logic              clk,
   input  logic              arst_n,
   // Responses and writes, high priority
   input  logic              resp_in_valid,
   input  umi_pkg::umi_msg_t resp_in_msg,
   output logic              resp_in_ready,
   // Read requests, low priority
   input  logic              req_in_valid,
   input  umi_pkg::umi_msg_t req_in_msg,
   output logic              req_in_ready,
   // Merged, registered output
   output logic              out_valid,
   output umi_pkg::umi_msg_t out_msg,
   input  logic              out_ready
);

   logic              mid_valid;  // Combiner -> slice
   umi_pkg::umi_msg_t mid_msg;
   logic              mid_ready;

   umi_combiner u_combiner (
      .clk           (clk),
      .arst_n        (arst_n),
      .resp_in_valid (resp_in_valid),
      .resp_in_msg   (resp_in_msg),
      .resp_in_ready (resp_in_ready),
      .req_in_valid  (req_in_valid),
      .req_in_msg    (req_in_msg),
      .req_in_ready  (req_in_ready),
      .out_valid     (mid_valid),
      .out_msg       (mid_msg),
      .out_ready     (mid_ready)
   );

   umi_out_slice #(
      .msg_t (umi_pkg::umi_msg_t)
   ) u_out_slice (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (mid_valid),
      .in_msg    (mid_msg),
      .in_ready  (mid_ready),
      .out_valid (out_valid),
      .out_msg   (out_msg),
      .out_ready (out_ready)
   );

endmodule

// ==== hdl/umi_mux.sv ====
/*
 * N-input message mux steered by a fixed-priority arbiter.
 * Payload type is a parameter so the same block can carry any packed
 * message. in_ready is the raw grant; the caller gates it with its own
 * downstream ready to form flow-through pushback.
 */
`timescale 1ns/1ps

module umi_mux #(
   parameter type msg_t = umi_pkg::umi_msg_t
) (
   input  logic                                   clk,
   input  logic                                   arst_n,
   // Inputs, index 0 is highest priority
   input  umi_arb_pkg::grant_t                    in_valid,
   input  msg_t [umi_arb_pkg::n_ports-1:0]        in_msg,
   output umi_arb_pkg::grant_t                    in_ready,
   // Output
   output logic                                   out_valid,
   output msg_t                                   out_msg,
   input  logic                                   out_ready
);

   umi_arb_pkg::grant_t          grant;
   logic                         stall;
   logic [$bits(msg_t)-1:0]      sel_bits;  // AND-OR accumulator

   // Offered but not taken, arbiter must hold its choice
   assign stall = out_valid & ~out_ready;

   umi_priority_arb u_arb (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (in_valid),
      .stall  (stall),
      .grant  (grant)
   );

   assign in_ready  = grant;
   assign out_valid = |(grant & in_valid);

   // One-hot select, no priority chain in the datapath
   always_comb begin
      sel_bits = '0;
      for (int i = 0; i < umi_arb_pkg::n_ports; i++) begin
         sel_bits = sel_bits | (in_msg[i] & {$bits(msg_t){grant[i]}});
      end
   end

   assign out_msg = msg_t'(sel_bits);

endmodule

// ==== hdl/umi_out_slice.sv ====
/*
 * Two-entry skid register slice.
 * Cuts every path between its two sides: out_* come from flops and
 * in_ready is the inverse of the skid valid flop. Sustains one beat per
 * cycle; under a stall it absorbs one extra beat, then drops in_ready.
 */
`timescale 1ns/1ps

module umi_out_slice #(
   parameter type msg_t = umi_pkg::umi_msg_t
) (
   input  logic clk,
   input  logic arst_n,
   // Upstream side
   input  logic in_valid,
   input  msg_t in_msg,
   output logic in_ready,
   // Downstream side
   output logic out_valid,
   output msg_t out_msg,
   input  logic out_ready
);

   logic skid_valid;   // Second entry occupied
   msg_t skid_msg;
   logic accept;       // Beat taken from upstream
   logic main_free;    // Main register may load this edge

   assign in_ready  = ~skid_valid;              // Ready straight off a flop
   assign accept    = in_valid & in_ready;
   assign main_free = ~out_valid | out_ready;   // Empty or being drained

   // Control state
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         if (main_free) begin
            out_valid  <= skid_valid | accept;  // Skid first, then input
            skid_valid <= 1'b0;                 // Skid always drains here
         end else if (accept) begin
            skid_valid <= 1'b1;                 // Main stuck, park the beat
         end
      end
   end

   // Payload, follows the valid flops
   always_ff @(posedge clk) begin
      if (main_free) begin
         if (skid_valid) begin
            out_msg <= skid_msg;    // Older beat goes out first
         end else if (accept) begin
            out_msg <= in_msg;
         end
      end
      if (accept && !main_free) begin
         skid_msg <= in_msg;
      end
   end

endmodule

// ==== hdl/umi_pkg.sv ====
/*
 * UMI message format shared by the combiner datapath and the testbench.
 * A message is one beat: command word, destination and source address,
 * and payload. Reference fields by scoped name, e.g. umi_pkg::umi_msg_t.
 * Widths here set the width of every message port in the design.
 */
package umi_pkg;

   // Field widths
   localparam int aw = 64;   // Address width, dst and src alike
   localparam int cw = 32;   // Command word
   localparam int uw = 256;  // Payload, one full beat

   // Single-beat message, 416 bits
   // cmd sits in the top bits so a waveform shows it first
   typedef struct packed {
      logic [cw-1:0] cmd;       // Opcode and size, not decoded here
      logic [aw-1:0] dst_addr;  // Destination address
      logic [aw-1:0] src_addr;  // Return address for responses
      logic [uw-1:0] payload;   // Data
   } umi_msg_t;

endpackage

// ==== hdl/umi_priority_arb.sv ====
/*
 * Fixed-priority arbiter, lowest index wins.
 * The grant is locked while the mux output is stalled so the message
 * on offer cannot be preempted. Lock is registered, which keeps the
 * stall -> grant path free of combinational loops through the mux.
 */
`timescale 1ns/1ps

module umi_priority_arb (
   input  logic                  clk,
   input  logic                  arst_n,
   input  umi_arb_pkg::grant_t   valid,   // Request per port
   input  logic                  stall,   // Mux output valid and not ready
   output umi_arb_pkg::grant_t   grant    // One-hot
);

   umi_arb_pkg::grant_t prio_grant;  // Unlocked choice
   umi_arb_pkg::grant_t grant_q;     // Grant seen during the stall
   logic                lock_q;      // Previous cycle was stalled

   // Lowest set bit is the highest priority requester
   assign prio_grant = valid & (~valid + umi_arb_pkg::grant_t'(1));

   // Old grant holds while locked
   assign grant = lock_q ? grant_q : prio_grant;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lock_q  <= 1'b0;
         grant_q <= '0;
      end else begin
         lock_q <= stall;         // Clears on the accepting edge
         if (stall) begin
            grant_q <= grant;     // Re-captures same value while locked
         end
      end
   end

endmodule

// ==== sim/umi_merge_checker.sv ====
/*
 * Scoreboard for the UMI merge testbench.
 * Models the arbiter lock and the slice occupancy from the DUT ports only,
 * checks both input readies and out_valid every cycle, and compares each
 * output transfer with the oldest accepted message.
 */
`timescale 1ns/1ps

module umi_merge_checker (
   input  logic              clk,
   input  logic              arst_n,
   input  int                phase,          // Current test, for error lines
   input  logic              resp_in_valid,
   input  umi_pkg::umi_msg_t resp_in_msg,
   input  logic              resp_in_ready,
   input  logic              req_in_valid,
   input  umi_pkg::umi_msg_t req_in_msg,
   input  logic              req_in_ready,
   input  logic              out_valid,
   input  umi_pkg::umi_msg_t out_msg,
   input  logic              out_ready,
   output int                errors,
   output int                pending,        // Accepted, not yet delivered
   output int                accepted,
   output int                delivered
);

   umi_pkg::umi_msg_t exp_q[$];              // Expected output order
   int                err_cnt = 0;
   int                acc_cnt = 0;
   int                del_cnt = 0;
   int                cnt_m;                 // Beats held in the slice, 0..2
   logic              lock_m;                // Previous cycle stalled
   int                held_port;             // Grant kept under the lock

   assign errors    = err_cnt;
   assign accepted  = acc_cnt;
   assign delivered = del_cnt;

   function automatic string phase_name(input int p);
      case (p)
         0:       return "reset";
         1:       return "pass_resp";
         2:       return "pass_req";
         3:       return "priority";
         4:       return "grant_lock";
         5:       return "random";
         default: return "drain";
      endcase
   endfunction

   // Expected grant, -1 for none
   // Lowest index wins unless the last cycle stalled, then the held grant
   function automatic int ref_grant(input logic v_resp, input logic v_req,
                                    input logic lock, input int held);
      if (lock) return held;
      if (v_resp) return umi_arb_pkg::port_resp;
      if (v_req) return umi_arb_pkg::port_req;
      return -1;
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s %s: expected %0b, actual %0b",
                  phase_name(phase), name, exp, act);
         err_cnt++;
      end
   endtask

   always @(posedge clk) begin
      int                g;
      logic              mid_rdy;
      logic              mid_vld;
      int                push;
      int                pop;
      umi_pkg::umi_msg_t head;
      if (!arst_n) begin
         check_bit("out_valid_in_reset", 1'b0, out_valid);
         cnt_m     = 0;
         lock_m    = 1'b0;
         held_port = -1;
         exp_q.delete();
      end else begin
         g       = ref_grant(resp_in_valid, req_in_valid, lock_m, held_port);
         mid_rdy = (cnt_m < 2);              // Skid entry still free
         mid_vld = (g == umi_arb_pkg::port_resp) ? resp_in_valid :
                   (g == umi_arb_pkg::port_req)  ? req_in_valid  : 1'b0;
         check_bit("resp_in_ready", mid_rdy && g == umi_arb_pkg::port_resp, resp_in_ready);
         check_bit("req_in_ready", mid_rdy && g == umi_arb_pkg::port_req, req_in_ready);
         check_bit("out_valid", cnt_m > 0, out_valid);  // One cycle after accept
         pop  = 0;
         push = 0;
         if (out_valid && out_ready) begin
            pop = 1;
            del_cnt++;
            if (exp_q.size() == 0) begin
               $display("Output transfer in %s with no message waiting", phase_name(phase));
               err_cnt++;
            end else begin
               head = exp_q.pop_front();
               if (out_msg !== head) begin
                  $display("[FAIL] %s out_msg: expected %h, actual %h",
                           phase_name(phase), head, out_msg);
                  err_cnt++;
               end
            end
         end
         if (resp_in_valid && resp_in_ready) begin
            exp_q.push_back(resp_in_msg);
            push++;
         end
         if (req_in_valid && req_in_ready) begin
            exp_q.push_back(req_in_msg);
            push++;
         end
         acc_cnt += push;
         if (mid_vld && !mid_rdy) held_port = g;    // Stall captures the grant
         lock_m = mid_vld && !mid_rdy;
         cnt_m  = cnt_m + push - pop;
      end
      pending = exp_q.size();
   end

endmodule

// ==== sim/umi_merge_tb.sv ====
/*
 * Testbench for the UMI merge top level.
 * Drives both inputs on the falling clock edge, runs directed phases for
 * reset, pass-through, priority and grant lock, then random back-pressure
 * and a drain. The checker instance does all comparisons; this module
 * holds clock, reset, stimulus and the final report.
 */
`timescale 1ns/1ps

module umi_merge_tb;

   logic              clk;
   logic              arst_n;
   logic              resp_in_valid;
   umi_pkg::umi_msg_t resp_in_msg;
   logic              resp_in_ready;
   logic              req_in_valid;
   umi_pkg::umi_msg_t req_in_msg;
   logic              req_in_ready;
   logic              out_valid;
   umi_pkg::umi_msg_t out_msg;
   logic              out_ready;
   logic              resp_fire = 1'b0;  // Handshake at the last rising edge
   logic              req_fire  = 1'b0;
   int                seed;
   int                resp_seq;          // Per-source sequence numbers
   int                req_seq;
   int                phase;
   int                tb_errors;
   int                errors;
   int                pending;
   int                accepted;
   int                delivered;

   always #50 clk = ~clk;                // 100 ns period

   always @(posedge clk) begin
      resp_fire <= resp_in_valid & resp_in_ready;
      req_fire  <= req_in_valid & req_in_ready;
   end

   umi_merge_top u_umi_merge_top (
      .clk (clk), .arst_n (arst_n),
      .resp_in_valid (resp_in_valid), .resp_in_msg (resp_in_msg),
      .resp_in_ready (resp_in_ready),
      .req_in_valid (req_in_valid), .req_in_msg (req_in_msg),
      .req_in_ready (req_in_ready),
      .out_valid (out_valid), .out_msg (out_msg), .out_ready (out_ready)
   );

   umi_merge_checker u_checker (
      .clk (clk), .arst_n (arst_n), .phase (phase),
      .resp_in_valid (resp_in_valid), .resp_in_msg (resp_in_msg),
      .resp_in_ready (resp_in_ready),
      .req_in_valid (req_in_valid), .req_in_msg (req_in_msg),
      .req_in_ready (req_in_ready),
      .out_valid (out_valid), .out_msg (out_msg), .out_ready (out_ready),
      .errors (errors), .pending (pending),
      .accepted (accepted), .delivered (delivered)
   );

   // True with the given percentage
   function automatic logic roll(input int pct);
      return ({$random(seed)} % 100) < pct;
   endfunction

   // Source tag in the top byte, sequence number in the low word
   function automatic umi_pkg::umi_msg_t make_msg(input logic [7:0] tag, input int seq);
      umi_pkg::umi_msg_t m;
      m                  = '0;
      m.cmd              = $random(seed);
      m.dst_addr         = {$random(seed), $random(seed)};
      m.src_addr         = {$random(seed), $random(seed)};
      m.payload[255:248] = tag;
      m.payload[247:216] = $random(seed);  // Filler
      m.payload[31:0]    = seq;
      return m;
   endfunction

   // One falling edge; a source holds its message until it is taken
   task automatic drive_cycle(input int p_resp, input int p_req, input int p_rdy);
      @(negedge clk);
      if (!resp_in_valid || resp_fire) begin
         resp_in_valid = roll(p_resp);
         if (resp_in_valid) begin
            resp_in_msg = make_msg(8'ha0, resp_seq);
            resp_seq++;
         end
      end
      if (!req_in_valid || req_fire) begin
         req_in_valid = roll(p_req);
         if (req_in_valid) begin
            req_in_msg = make_msg(8'hb1, req_seq);
            req_seq++;
         end
      end
      out_ready = roll(p_rdy);
   endtask

   task automatic run_cycles(input int n, input int p_resp, input int p_req, input int p_rdy);
      repeat (n) drive_cycle(p_resp, p_req, p_rdy);
   endtask

   // Let held messages go before the next phase
   task automatic wait_idle(input int limit);
      int n;
      n = 0;
      while ((resp_in_valid || req_in_valid) && n < limit) begin
         drive_cycle(0, 0, 100);
         n++;
      end
      if (resp_in_valid || req_in_valid) begin
         $display("Timeout: a source still holds valid after %0d cycles", limit);
         tb_errors++;
      end
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (pending != 0 && n < limit) begin
         drive_cycle(0, 0, 100);
         n++;
      end
      if (pending != 0) begin
         $display("Timeout: %0d messages never reached the output", pending);
         tb_errors++;
      end
   endtask

   initial begin
      seed          = 92450;
      clk           = 1'b0;
      arst_n        = 1'b1;
      resp_in_valid = 1'b0;
      resp_in_msg   = '0;
      req_in_valid  = 1'b0;
      req_in_msg    = '0;
      out_ready     = 1'b0;
      resp_seq      = 0;
      req_seq       = 0;
      phase         = 0;
      tb_errors     = 0;
      #1 arst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      phase = 1;                          // Responses only, consumer always ready
      run_cycles(40, 60, 0, 100);
      wait_idle(50);
      phase = 2;                          // Requests only
      run_cycles(40, 0, 60, 100);
      wait_idle(50);
      phase = 3;                          // Both saturated, responses must win
      run_cycles(12, 100, 100, 100);
      wait_idle(50);
      phase = 4;
      run_cycles(6, 0, 100, 0);           // Fill slice, lock onto the request
      run_cycles(4, 100, 100, 0);         // Response shows up under the lock
      run_cycles(10, 100, 100, 100);      // Held request must go first
      phase = 5;
      run_cycles(400, 50, 50, 50);
      phase = 6;
      wait_idle(100);
      wait_drain(100);
      if (accepted == 0) begin
         $display("No message was accepted during the run");
         tb_errors++;
      end
      $display("accepted=%0d delivered=%0d pending=%0d check_errors=%0d tb_errors=%0d",
               accepted, delivered, pending, errors, tb_errors);
      if (errors == 0 && tb_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== umi_merge.f ====
hdl/umi_pkg.sv
hdl/umi_arb_pkg.sv
hdl/umi_priority_arb.sv
hdl/umi_mux.sv
hdl/umi_combiner.sv
hdl/umi_out_slice.sv
hdl/umi_merge_top.sv
sim/umi_merge_checker.sv
sim/umi_merge_tb.sv
